/* hdl/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define CPU_XLEN      32
`define CPU_REG_BITS  5
`define CPU_RESET_PC  32'h1c00_0000

// 3R format, matched on inst[31:15]
`define OPC_ADD_W     17'h00020
`define OPC_SUB_W     17'h00022
`define OPC_SLT       17'h00024
`define OPC_SLTU      17'h00025
`define OPC_NOR       17'h00028
`define OPC_AND       17'h00029
`define OPC_OR        17'h0002a
`define OPC_XOR       17'h0002b

// 2RI12 format, inst[31:22]
`define OPC_ADDI_W    10'h00a
`define OPC_LD_W      10'h0a2
`define OPC_ST_W      10'h0a6

// 1RI20 format, inst[31:25]
`define OPC_LU12I_W   7'h0a

// branch formats, inst[31:26]
`define OPC_JIRL      6'h13
`define OPC_B         6'h14
`define OPC_BL        6'h15
`define OPC_BEQ       6'h16
`define OPC_BNE       6'h17

`endif

/* hdl/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]     word_t;
    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_LUI   // pass the upper immediate on src2
    } alu_op_t;

    typedef struct packed {
        word_t    pc;
        alu_op_t  alu_op;
        word_t    alu_src1;
        word_t    alu_src2;
        word_t    st_data;
        reg_idx_t dest;
        logic     rf_we;
        logic     mem_rd;
        logic     mem_wr;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     rf_we;
        logic     mem_rd;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     rf_we;
    } mem_wb_t;

    // one stage as seen by the forwarding logic
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
        logic     writes;
        logic     ready;
    } fwd_t;

    typedef struct packed {
        logic  en;
        logic  we;
        word_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        word_t    pc;
        logic     we;
        reg_idx_t wnum;
        word_t    wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

/* hdl/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load,
    input  logic     cancel,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) out_valid <= 1'b0;
        else out_valid <= in_valid && !cancel;   // cancel inserts a bubble
    end

    always_ff @(posedge clk) begin
        if (load) out_data <= in_data;
    end

    assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("stage valid is unknown");

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    input  logic              we,
    input  cpu_pkg::reg_idx_t waddr,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);
    import cpu_pkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) regs[waddr] <= wdata;
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    word_t diff;

    assign diff = src1 - src2;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: result = word_t'(src1 < src2);
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_XOR:  result = src1 ^ src2;
            ALU_LUI:  result = src2;   // immediate already shifted in decode
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module decode_unit (
    input  cpu_pkg::word_t    inst,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rj_value,
    input  cpu_pkg::word_t    rkd_value,
    output cpu_pkg::reg_idx_t rf_raddr1,
    output cpu_pkg::reg_idx_t rf_raddr2,
    output logic              uses_rj,
    output logic              uses_rkd,
    output cpu_pkg::id_ex_t   id_ex,
    output logic              br_taken,
    output cpu_pkg::word_t    br_target
);
    import cpu_pkg::*;

    reg_idx_t rd, rj, rk;
    logic     inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic     inst_nor, inst_and, inst_or, inst_xor;
    logic     inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w;
    logic     inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic     is_rr, src_reg_is_rd, src1_is_pc, src2_is_imm;
    word_t    si12, ui20, offs16, offs26, imm;
    alu_op_t  op;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    assign inst_add_w   = inst[31:15] == `OPC_ADD_W;
    assign inst_sub_w   = inst[31:15] == `OPC_SUB_W;
    assign inst_slt     = inst[31:15] == `OPC_SLT;
    assign inst_sltu    = inst[31:15] == `OPC_SLTU;
    assign inst_nor     = inst[31:15] == `OPC_NOR;
    assign inst_and     = inst[31:15] == `OPC_AND;
    assign inst_or      = inst[31:15] == `OPC_OR;
    assign inst_xor     = inst[31:15] == `OPC_XOR;
    assign inst_addi_w  = inst[31:22] == `OPC_ADDI_W;
    assign inst_ld_w    = inst[31:22] == `OPC_LD_W;
    assign inst_st_w    = inst[31:22] == `OPC_ST_W;
    assign inst_lu12i_w = inst[31:25] == `OPC_LU12I_W;
    assign inst_jirl    = inst[31:26] == `OPC_JIRL;
    assign inst_b       = inst[31:26] == `OPC_B;
    assign inst_bl      = inst[31:26] == `OPC_BL;
    assign inst_beq     = inst[31:26] == `OPC_BEQ;
    assign inst_bne     = inst[31:26] == `OPC_BNE;

    assign is_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu |
                   inst_nor | inst_and | inst_or | inst_xor;

    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign src_reg_is_rd = inst_st_w | inst_beq | inst_bne;  // rd is read, not written
    assign src1_is_pc    = inst_bl | inst_jirl;              // link value pc+4
    assign src2_is_imm   = inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w | src1_is_pc;
    assign imm = src1_is_pc ? word_t'(4) : inst_lu12i_w ? ui20 : si12;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = src_reg_is_rd ? rd : rk;
    assign uses_rj   = is_rr | inst_addi_w | inst_ld_w | inst_st_w |
                       inst_beq | inst_bne | inst_jirl;
    assign uses_rkd  = is_rr | src_reg_is_rd;

    always_comb begin
        op = ALU_ADD;   // addi, loads, stores and links add too
        if (inst_sub_w) op = ALU_SUB;
        else if (inst_slt) op = ALU_SLT;
        else if (inst_sltu) op = ALU_SLTU;
        else if (inst_and) op = ALU_AND;
        else if (inst_or) op = ALU_OR;
        else if (inst_nor) op = ALU_NOR;
        else if (inst_xor) op = ALU_XOR;
        else if (inst_lu12i_w) op = ALU_LUI;
    end

    always_comb begin
        id_ex.pc       = pc;
        id_ex.alu_op   = op;
        id_ex.alu_src1 = src1_is_pc ? pc : rj_value;
        id_ex.alu_src2 = src2_is_imm ? imm : rkd_value;
        id_ex.st_data  = rkd_value;
        id_ex.dest     = inst_bl ? reg_idx_t'(1) : rd;
        id_ex.rf_we    = is_rr | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_bl | inst_jirl;
        id_ex.mem_rd   = inst_ld_w;
        id_ex.mem_wr   = inst_st_w;
    end

    assign br_taken  = inst_b | inst_bl | inst_jirl |
                       (inst_beq && rj_value == rkd_value) |
                       (inst_bne && rj_value != rkd_value);
    assign br_target = inst_jirl ? rj_value + offs16 :
                       pc + ((inst_b | inst_bl) ? offs26 : offs16);

endmodule

`default_nettype wire

/* hdl/hazard_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_forward (
    input  cpu_pkg::reg_idx_t rf_raddr1,
    input  cpu_pkg::reg_idx_t rf_raddr2,
    input  logic              uses_rj,
    input  logic              uses_rkd,
    input  cpu_pkg::word_t    rf_rdata1,
    input  cpu_pkg::word_t    rf_rdata2,
    input  cpu_pkg::fwd_t     fwd_ex,
    input  cpu_pkg::fwd_t     fwd_mem,
    input  cpu_pkg::fwd_t     fwd_wb,
    input  logic              id_valid,
    output cpu_pkg::word_t    rj_value,
    output cpu_pkg::word_t    rkd_value,
    output logic              stall
);
    import cpu_pkg::*;

    fwd_t pick1, pick2;   // youngest matching writer, writes=0 if none

    function automatic fwd_t youngest(reg_idx_t idx, fwd_t ex, fwd_t mem, fwd_t wb);
        fwd_t none;
        none = '0;
        if (idx == '0) return none;    // r0 stays zero
        if (ex.writes && ex.dest == idx) return ex;
        if (mem.writes && mem.dest == idx) return mem;
        if (wb.writes && wb.dest == idx) return wb;
        return none;
    endfunction

    assign pick1     = youngest(rf_raddr1, fwd_ex, fwd_mem, fwd_wb);
    assign pick2     = youngest(rf_raddr2, fwd_ex, fwd_mem, fwd_wb);
    assign rj_value  = pick1.writes ? pick1.value : rf_rdata1;
    assign rkd_value = pick2.writes ? pick2.value : rf_rdata2;

    always_comb begin
        stall = id_valid && ((uses_rj && pick1.writes && !pick1.ready) ||
                             (uses_rkd && pick2.writes && !pick2.ready));
    end

endmodule

`default_nettype wire

/* hdl/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_core (
    input  logic                clk,
    input  logic                reset,
    output logic                inst_sram_en,
    output cpu_pkg::word_t      inst_sram_addr,
    input  cpu_pkg::word_t      inst_sram_rdata,
    output cpu_pkg::data_req_t  data_req,
    input  cpu_pkg::word_t      data_sram_rdata,
    output cpu_pkg::wb_trace_t  trace
);
    import cpu_pkg::*;

    word_t    pc;
    word_t    id_pc;
    logic     id_valid;
    logic     redirect;
    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    logic     uses_rj;
    logic     uses_rkd;
    word_t    rj_value;
    word_t    rkd_value;
    logic     br_taken;
    word_t    br_target;
    logic     stall;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    logic     ex_valid;
    word_t    ex_result;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    logic     mem_valid;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    logic     wb_valid;
    logic     rf_we;
    fwd_t     fwd_ex;
    fwd_t     fwd_mem;
    fwd_t     fwd_wb;

    // fetch: sram output holds while en is low, so a stalled decode keeps its word
    assign redirect       = id_valid && br_taken && !stall;
    assign inst_sram_en   = !stall;
    assign inst_sram_addr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `CPU_RESET_PC;
            id_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= redirect ? br_target : pc + word_t'(4);
            id_valid <= !redirect;  // drop the slot fetched behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) id_pc <= pc;
    end

    decode_unit u_decode (
        .inst      (inst_sram_rdata),
        .pc        (id_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .uses_rj   (uses_rj),
        .uses_rkd  (uses_rkd),
        .id_ex     (id_ex_d),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    hazard_forward u_hazard (
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .uses_rj   (uses_rj),
        .uses_rkd  (uses_rkd),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .fwd_ex    (fwd_ex),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .id_valid  (id_valid),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk (clk), .reset (reset), .load (id_valid && !stall), .cancel (stall),
        .in_valid (id_valid), .in_data (id_ex_d), .out_valid (ex_valid), .out_data (id_ex_q)
    );

    alu u_alu (
        .alu_op (id_ex_q.alu_op),
        .src1   (id_ex_q.alu_src1),
        .src2   (id_ex_q.alu_src2),
        .result (ex_result)
    );

    always_comb begin
        data_req.en    = ex_valid && (id_ex_q.mem_rd || id_ex_q.mem_wr);
        data_req.we    = ex_valid && id_ex_q.mem_wr;
        data_req.addr  = ex_result;
        data_req.wdata = id_ex_q.st_data;
        ex_mem_d       = '{pc: id_ex_q.pc, result: ex_result, dest: id_ex_q.dest,
                           rf_we: id_ex_q.rf_we, mem_rd: id_ex_q.mem_rd};
        fwd_ex         = '{dest: id_ex_q.dest, value: ex_result,
                           writes: ex_valid && id_ex_q.rf_we, ready: !id_ex_q.mem_rd};
    end

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk (clk), .reset (reset), .load (ex_valid), .cancel (1'b0),
        .in_valid (ex_valid), .in_data (ex_mem_d), .out_valid (mem_valid), .out_data (ex_mem_q)
    );

    always_comb begin
        mem_wb_d.pc     = ex_mem_q.pc;
        mem_wb_d.result = ex_mem_q.mem_rd ? data_sram_rdata : ex_mem_q.result;
        mem_wb_d.dest   = ex_mem_q.dest;
        mem_wb_d.rf_we  = ex_mem_q.rf_we;
        fwd_mem = '{dest: ex_mem_q.dest, value: mem_wb_d.result,
                    writes: mem_valid && ex_mem_q.rf_we, ready: 1'b1};
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk (clk), .reset (reset), .load (mem_valid), .cancel (1'b0),
        .in_valid (mem_valid), .in_data (mem_wb_d), .out_valid (wb_valid), .out_data (mem_wb_q)
    );

    assign rf_we = wb_valid && mem_wb_q.rf_we;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (mem_wb_q.dest),
        .wdata  (mem_wb_q.result),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    always_comb begin
        fwd_wb = '{dest: mem_wb_q.dest, value: mem_wb_q.result, writes: rf_we, ready: 1'b1};
        trace  = '{pc: mem_wb_q.pc, we: rf_we, wnum: mem_wb_q.dest, wdata: mem_wb_q.result};
    end

    // word accesses only
    assert property (@(posedge clk) disable iff (reset)
        data_req.en |-> data_req.addr[1:0] == 2'b00)
        else $error("misaligned data access at %h", data_req.addr);

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released on a falling edge
    end

endmodule

`default_nettype wire

/* tests/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 256;   // byte addresses 0 to 0x3ff
    localparam int MODEL_STEPS = 64;

    localparam int OP_ADD = 0, OP_SUB = 1, OP_SLT = 2, OP_SLTU = 3;
    localparam int OP_AND = 4, OP_OR = 5, OP_NOR = 6, OP_XOR = 7;
    localparam int OP_ADDI = 8, OP_LU12I = 9, OP_LD = 10, OP_ST = 11;
    localparam int OP_BEQ = 12, OP_BNE = 13, OP_B = 14, OP_BL = 15, OP_JIRL = 16;

    logic      clk;
    logic      por;
    logic      test_reset;
    logic      dut_reset;
    logic      inst_sram_en;
    word_t     inst_sram_addr;
    word_t     inst_rdata;
    data_req_t data_req;
    word_t     data_rdata;
    wb_trace_t trace;

    // program under test, binary and in the form the reference model steps through
    word_t p_word [0:IMEM_WORDS-1];
    int    p_op   [0:IMEM_WORDS-1];
    int    p_rd   [0:IMEM_WORDS-1];
    int    p_rj   [0:IMEM_WORDS-1];
    int    p_rk   [0:IMEM_WORDS-1];
    int    p_imm  [0:IMEM_WORDS-1];
    int    plen;

    word_t imem [0:IMEM_WORDS-1];
    word_t dmem [0:DMEM_WORDS-1];

    wb_trace_t   exp_q [$];
    string       test_name;
    logic        monitor_on;
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          budget_cycles;
    int          cycles;

    assign dut_reset = por | test_reset;

    tb_clock_gen clk_gen (
        .clk   (clk),
        .reset (por)
    );

    cpu_core dut0 (
        .clk             (clk),
        .reset           (dut_reset),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_rdata),
        .data_req        (data_req),
        .data_sram_rdata (data_rdata),
        .trace           (trace)
    );

    function automatic word_t fill_word(word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic word_t fetch_word(word_t addr);
        word_t off;
        off = addr - `CPU_RESET_PC;
        if (off < IMEM_WORDS * 4) return imem[off >> 2];
        return '0;   // decodes as no instruction
    endfunction

    // synchronous SRAMs, output holds while en is low
    always @(posedge clk) begin
        if (inst_sram_en) inst_rdata <= fetch_word(inst_sram_addr);
    end

    always @(posedge clk) begin
        if (data_req.en) begin
            if (data_req.addr >= DMEM_WORDS * 4) begin
                errors = errors + 1;
                $display("%s: data access outside memory at %h", test_name, data_req.addr);
            end else if (data_req.we) begin
                dmem[data_req.addr[9:2]] <= data_req.wdata;
            end else begin
                data_rdata <= dmem[data_req.addr[9:2]];
            end
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    task automatic emit(input int op, input int rd, input int rj, input int rk, input int imm);
        logic [4:0] d;
        logic [4:0] j;
        logic [4:0] k;
        word_t      w;
        d = rd[4:0];
        j = rj[4:0];
        k = rk[4:0];
        case (op)
            OP_ADD:   w = {`OPC_ADD_W, k, j, d};
            OP_SUB:   w = {`OPC_SUB_W, k, j, d};
            OP_SLT:   w = {`OPC_SLT, k, j, d};
            OP_SLTU:  w = {`OPC_SLTU, k, j, d};
            OP_AND:   w = {`OPC_AND, k, j, d};
            OP_OR:    w = {`OPC_OR, k, j, d};
            OP_NOR:   w = {`OPC_NOR, k, j, d};
            OP_XOR:   w = {`OPC_XOR, k, j, d};
            OP_ADDI:  w = {`OPC_ADDI_W, imm[11:0], j, d};
            OP_LD:    w = {`OPC_LD_W, imm[11:0], j, d};
            OP_ST:    w = {`OPC_ST_W, imm[11:0], j, d};
            OP_LU12I: w = {`OPC_LU12I_W, imm[19:0], d};
            OP_JIRL:  w = {`OPC_JIRL, imm[15:0], j, d};
            OP_BEQ:   w = {`OPC_BEQ, imm[15:0], j, d};
            OP_BNE:   w = {`OPC_BNE, imm[15:0], j, d};
            OP_B:     w = {`OPC_B, imm[15:0], imm[25:16]};
            OP_BL:    w = {`OPC_BL, imm[15:0], imm[25:16]};
            default:  w = '0;
        endcase
        p_word[plen] = w;
        p_op[plen]   = op;
        p_rd[plen]   = rd;
        p_rj[plen]   = rj;
        p_rk[plen]   = rk;
        p_imm[plen]  = imm;   // branch offsets counted in instructions
        plen = plen + 1;
    endtask

    task automatic load_value(input int r);
        emit(OP_LU12I, r, 0, 0, rand_bits(20));
        emit(OP_ADDI, r, r, 0, rand_bits(11));
    endtask

    // instruction-level reference model, fills exp_q with the register writes in order
    task automatic build_expected();
        word_t     regs [0:31];
        word_t     mem [0:DMEM_WORDS-1];
        word_t     pc, next, a, b, d, res, addr;
        wb_trace_t e;
        int        idx, dest, steps;
        logic      wr;
        exp_q.delete();
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) mem[i] = fill_word(word_t'(i * 4));
        pc = `CPU_RESET_PC;
        steps = 0;
        while (steps < MODEL_STEPS) begin
            idx = int'((pc - `CPU_RESET_PC) >> 2);
            if (idx >= plen) begin
                errors = errors + 1;
                $display("%s: reference model left the program at %h", test_name, pc);
                break;
            end
            if (p_op[idx] == OP_B && p_imm[idx] == 0) break;   // closing self-loop
            a = regs[p_rj[idx]];
            b = regs[p_rk[idx]];
            d = regs[p_rd[idx]];
            next = pc + 4;
            dest = p_rd[idx];
            wr = 1'b1;
            res = '0;
            addr = a + word_t'(p_imm[idx]);
            case (p_op[idx])
                OP_ADD:   res = a + b;
                OP_SUB:   res = a - b;
                OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
                OP_AND:   res = a & b;
                OP_OR:    res = a | b;
                OP_NOR:   res = ~(a | b);
                OP_XOR:   res = a ^ b;
                OP_ADDI:  res = addr;
                OP_LU12I: res = {p_imm[idx][19:0], 12'b0};
                OP_LD:    res = mem[addr[9:2]];
                OP_ST: begin
                    mem[addr[9:2]] = d;
                    wr = 1'b0;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == d) next = pc + word_t'(p_imm[idx] * 4);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != d) next = pc + word_t'(p_imm[idx] * 4);
                end
                OP_B: begin
                    wr = 1'b0;
                    next = pc + word_t'(p_imm[idx] * 4);
                end
                OP_BL: begin
                    res = pc + 4;
                    dest = 1;
                    next = pc + word_t'(p_imm[idx] * 4);
                end
                OP_JIRL: begin
                    res = pc + 4;
                    next = a + word_t'(p_imm[idx] * 4);
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                e.pc = pc;
                e.we = 1'b1;
                e.wnum = reg_idx_t'(dest);
                e.wdata = res;
                exp_q.push_back(e);
                if (dest != 0) regs[dest] = res;   // r0 write still retires
            end
            pc = next;
            steps = steps + 1;
        end
    endtask

    // holds reset for 3 cycles, loads both memories, checks the state right after release
    task automatic reset_dut(input logic watch);
        @(negedge clk);
        test_reset = 1'b1;
        @(negedge clk);
        monitor_on = watch;   // trace.we already low here
        for (int i = 0; i < IMEM_WORDS; i++) imem[i] = (i < plen) ? p_word[i] : '0;
        for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(word_t'(i * 4));
        budget_cycles = budget_cycles + plen * 4;
        repeat (2) @(negedge clk);
        test_reset = 1'b0;
        checks = checks + 3;
        if (data_req.en !== 1'b0) begin
            errors = errors + 1;
            $display("FAIL %s: expected data_req.en 0, actual %b", test_name, data_req.en);
        end
        if (trace.we !== 1'b0) begin
            errors = errors + 1;
            $display("FAIL %s: expected trace.we 0, actual %b", test_name, trace.we);
        end
        if (inst_sram_addr !== `CPU_RESET_PC) begin
            errors = errors + 1;
            $display("FAIL %s: expected inst_sram_addr %h, actual %h",
                     test_name, `CPU_RESET_PC, inst_sram_addr);
        end
    endtask

    task automatic run_program();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < plen * 3 + 10) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (exp_q.size() != 0) begin
            errors = errors + 1;
            $display("%s: %0d register writes never retired, first missing at pc %h",
                     test_name, exp_q.size(), exp_q[0].pc);
            exp_q.delete();
        end
        repeat (6) @(negedge clk);   // late extra writes
    endtask

    task automatic execute_program();
        emit(OP_B, 0, 0, 0, 0);
        build_expected();
        reset_dut(1'b1);
        run_program();
    endtask

    always @(negedge clk) begin
        wb_trace_t want;
        if (monitor_on && trace.we === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors = errors + 1;
                $display("%s: extra retirement at pc %h writing r%0d",
                         test_name, trace.pc, trace.wnum);
            end else begin
                want = exp_q.pop_front();
                checks = checks + 1;
                if (trace.pc !== want.pc || trace.wnum !== want.wnum ||
                    trace.wdata !== want.wdata) begin
                    errors = errors + 1;
                    $display("FAIL %s: expected pc %h r%0d=%h, actual pc %h r%0d=%h",
                             test_name, want.pc, want.wnum, want.wdata,
                             trace.pc, trace.wnum, trace.wdata);
                end
            end
        end
    end

    task automatic test_alu_chain();
        test_name = "alu_chain";
        plen = 0;
        load_value(4);
        load_value(5);
        emit(OP_ADD, 6, 4, 5, 0);
        emit(OP_SUB, 7, 6, 4, 0);    // execute forward
        emit(OP_SLT, 8, 7, 6, 0);
        emit(OP_SLTU, 9, 5, 8, 0);
        emit(OP_AND, 10, 9, 7, 0);   // r7 from writeback
        emit(OP_OR, 11, 10, 4, 0);
        emit(OP_NOR, 12, 11, 6, 0);
        emit(OP_XOR, 13, 12, 5, 0);
        execute_program();
    endtask

    task automatic test_immediates();
        test_name = "immediates";
        plen = 0;
        emit(OP_ADDI, 4, 0, 0, -1);
        emit(OP_ADDI, 5, 0, 0, 2047);
        emit(OP_ADDI, 6, 0, 0, -2048);
        emit(OP_ADDI, 7, 5, 0, -100);
        emit(OP_LU12I, 8, 0, 0, 'h80000);
        emit(OP_LU12I, 9, 0, 0, rand_bits(20));
        emit(OP_ADDI, 0, 5, 0, 5);   // retires but r0 stays zero
        emit(OP_ADD, 10, 0, 5, 0);
        emit(OP_OR, 11, 0, 0, 0);
        execute_program();
    endtask

    task automatic test_memory();
        test_name = "memory";
        plen = 0;
        emit(OP_ADDI, 4, 0, 0, 'h100);
        load_value(5);
        emit(OP_ST, 5, 4, 0, 0);
        emit(OP_ST, 4, 4, 0, 8);
        emit(OP_LD, 6, 4, 0, 0);
        emit(OP_LD, 7, 4, 0, 8);
        emit(OP_LD, 8, 4, 0, 4);     // untouched word
        emit(OP_ADD, 9, 8, 6, 0);    // load-use
        emit(OP_LD, 10, 4, 0, 0);
        emit(OP_ADD, 11, 10, 10, 0);
        execute_program();
    endtask

    task automatic test_branches();
        test_name = "branches";
        plen = 0;
        emit(OP_ADDI, 4, 0, 0, 5);
        emit(OP_ADDI, 5, 0, 0, 5);
        emit(OP_ADDI, 6, 0, 0, 7);
        emit(OP_BEQ, 5, 4, 0, 2);    // taken
        emit(OP_ADDI, 7, 0, 0, 1);
        emit(OP_BNE, 6, 4, 0, 2);    // taken
        emit(OP_ADDI, 8, 0, 0, 2);
        emit(OP_BEQ, 6, 4, 0, 2);    // not taken
        emit(OP_ADDI, 9, 0, 0, 3);
        emit(OP_BNE, 5, 4, 0, 2);    // not taken
        emit(OP_ADDI, 10, 0, 0, 4);
        execute_program();
    endtask

    task automatic test_calls();
        test_name = "calls";
        plen = 0;
        emit(OP_BL, 0, 0, 0, 3);
        emit(OP_ADDI, 5, 0, 0, 11);  // return lands here
        emit(OP_B, 0, 0, 0, 4);
        emit(OP_ADDI, 6, 0, 0, 22);
        emit(OP_JIRL, 2, 1, 0, 0);
        emit(OP_ADDI, 7, 0, 0, 33);  // never reached
        emit(OP_LU12I, 8, 0, 0, `CPU_RESET_PC >> 12);
        emit(OP_JIRL, 3, 8, 0, 9);
        emit(OP_ADDI, 9, 0, 0, 44);
        emit(OP_ADDI, 10, 3, 0, 1);
        execute_program();
    endtask

    task automatic test_reset_mid_run();
        test_name = "reset_mid_run";
        plen = 0;
        emit(OP_ADDI, 4, 0, 0, 'h40);
        emit(OP_ST, 4, 4, 0, 0);
        emit(OP_ST, 4, 4, 0, 4);
        emit(OP_LD, 5, 4, 0, 4);
        emit(OP_ADD, 6, 5, 4, 0);
        emit(OP_B, 0, 0, 0, 0);
        build_expected();
        reset_dut(1'b0);
        repeat (5) @(negedge clk);   // stores in flight
        reset_dut(1'b1);
        run_program();
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles <= budget_cycles + 100) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("watchdog expired after %0d cycles in %s", cycles, test_name);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        test_reset    = 1'b0;
        monitor_on    = 1'b0;
        inst_rdata    = '0;
        data_rdata    = '0;
        lfsr          = 16'd42322;
        errors        = 0;
        checks        = 0;
        budget_cycles = 0;
        plen          = 0;
        test_name     = "startup";

        test_alu_chain();
        test_immediates();
        test_memory();
        test_branches();
        test_calls();
        test_reset_mid_run();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/decode_unit.sv
hdl/hazard_forward.sv
hdl/cpu_core.sv
tests/tb_clock_gen.sv
tests/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/pipe_reg.sv
      - hdl/regfile.sv
      - hdl/alu.sv
      - hdl/decode_unit.sv
      - hdl/hazard_forward.sv
      - hdl/cpu_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_cpu_core.sv
